// ==== flist.f ====
hdl/layer_geom_pkg.sv
hdl/axi_rd_pkg.sv
hdl/row_fetcher.sv
hdl/line_buffer.sv
hdl/window_streamer.sv
hdl/input_layer_top.sv
verification/input_layer_chk.sv
verification/tb_input_layer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_input_layer with Verilator, run it, decide from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_input_layer -Mdir obj_dir -f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_input_layer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

# the log decides first
if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0

// ==== verification/tb_input_layer.sv ====
// testbench: clock and reset, AXI read responder, case table, window and address checks
`timescale 1ns/100ps

module tb_input_layer;
	import layer_geom_pkg::*;
	import axi_rd_pkg::*;

	// one table entry, count is rows * cols * layers
	typedef struct packed {
		logic [DIM_W-1:0]  rows;
		logic [DIM_W-1:0]  cols;
		logic [DIM_W-1:0]  layers;
		logic [BASE_W-1:0] base;
		logic              stall;
		logic [15:0]       count;
	} case_t;

	localparam int NUM_CASES = 6;
	// cycles allowed for one whole run
	localparam int RUN_LIMIT = 60000;

	logic clk = 1'b0;
	logic reset_n;
	logic start;
	layer_cfg_t cfg;
	ar_req_t ar;
	logic arvalid;
	logic arready;
	logic [ID_W-1:0] arid;
	logic [2:0] arsize;
	logic [1:0] arburst;
	r_beat_t r;
	logic rvalid;
	logic rready;
	win_t win;
	logic win_valid;
	logic win_ready;
	logic busy;

	case_t cases [NUM_CASES];
	case_t cur;
	logic [31:0] rng;
	// responder, one burst open at most
	logic burst_open;
	logic beat_sent;
	logic [31:0] burst_addr;
	logic [7:0] burst_len;
	logic [7:0] beat_idx;
	int ar_cnt;
	int ar_layer;
	int ar_row;
	// next window expected
	int win_cnt;
	int exp_layer;
	int exp_row;
	int exp_col;

	input_layer_top u_input_layer_top (.*);

	bind input_layer_top input_layer_chk u_chk (
		.clk(clk),
		.reset_n(reset_n),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rvalid(rvalid),
		.rready(rready),
		.win(win),
		.win_valid(win_valid),
		.win_ready(win_ready),
		.busy(busy)
	);

	// ------------------------------------------------------------
	// reference rules
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// memory byte from the full address
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] v;
		v = a * 32'd7 + (a >> 12);
		return v[7:0];
	endfunction

	// 4 KiB per layer, 64 bytes per row
	function automatic logic [31:0] row_start(input int l, input int y);
		return (32'(cur.base) + 32'(l)) * 32'd4096 + 32'(y) * 32'd64;
	endfunction

	// row-major, top-left byte in the msbs, zero outside the layer
	function automatic logic [71:0] expected_window(input int l, input int y, input int x);
		logic [71:0] d;
		int yy;
		int xx;
		d = '0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				yy = y + i - 1;
				xx = x + j - 1;
				if (yy >= 0 && yy < int'(cur.rows) && xx >= 0 && xx < int'(cur.cols)) begin
					d[71 - 8*(3*i + j) -: 8] = mem_byte(row_start(l, yy) + 32'(xx));
				end
			end
		end
		return d;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// ------------------------------------------------------------
	// per-transfer checks
	// ------------------------------------------------------------
	task automatic check_ar();
		logic [31:0] exp_addr;
		logic [7:0] exp_len;
		exp_addr = row_start(ar_layer, ar_row);
		// ceil(cols/8) beats
		exp_len = 8'((int'(cur.cols) + 7) / 8 - 1);
		assert (ar.addr == exp_addr)
			else report_failure($sformatf("[FAIL] ar.addr got %h expected %h", ar.addr, exp_addr));
		assert (ar.len == exp_len)
			else report_failure($sformatf("[FAIL] ar.len got %h expected %h", ar.len, exp_len));
		assert (arid == 3'd1 && arsize == 3'd3 && arburst == 2'b01)
			else report_failure($sformatf("[FAIL] arid/arsize/arburst got %h/%h/%h expected 1/3/1",
				arid, arsize, arburst));
		assert (!burst_open)
			else report_failure("a read burst was requested while another one was still open");
		burst_addr = ar.addr;
		burst_len = ar.len;
		beat_idx = '0;
		burst_open = 1'b1;
		ar_cnt++;
		ar_row++;
		if (ar_row == int'(cur.rows)) begin
			ar_row = 0;
			ar_layer++;
		end
	endtask

	task automatic present_beat();
		for (int k = 0; k < 8; k++) begin
			r.data[8*k +: 8] = mem_byte(burst_addr + 32'(beat_idx) * 32'd8 + 32'(k));
		end
		r.last = (beat_idx == burst_len);
		r.resp = 2'b00;
		rvalid = 1'b1;
	endtask

	task automatic check_window();
		logic [71:0] exp_data;
		exp_data = expected_window(exp_layer, exp_row, exp_col);
		assert (win_cnt < int'(cur.count))
			else report_failure("a window arrived after the expected number of windows");
		assert (win.layer == DIM_W'(exp_layer) && win.row == DIM_W'(exp_row)
			&& win.col == DIM_W'(exp_col))
			else report_failure($sformatf("[FAIL] win.layer/row/col got %h/%h/%h expected %h/%h/%h",
				win.layer, win.row, win.col, exp_layer, exp_row, exp_col));
		assert (win.data == exp_data)
			else report_failure($sformatf("[FAIL] win.data got %h expected %h", win.data, exp_data));
		win_cnt++;
		// layer-major walk
		exp_col++;
		if (exp_col == int'(cur.cols)) begin
			exp_col = 0;
			exp_row++;
			if (exp_row == int'(cur.rows)) begin
				exp_row = 0;
				exp_layer++;
			end
		end
	endtask

	// ------------------------------------------------------------
	// memory responder and window sink, all driven on the falling edge
	// ------------------------------------------------------------
	always @(negedge clk) begin
		// bound assertions count their failures
		if (u_input_layer_top.u_chk.fail_cnt != 0) begin
			report_failure("a bound handshake assertion failed");
		end
		rng = xorshift32(rng);
		// beat taken on the last rising edge
		if (beat_sent) begin
			rvalid = 1'b0;
			beat_sent = 1'b0;
		end
		if (burst_open && !rvalid && (!cur.stall || rng[1:0] != 2'd0)) begin
			present_beat();
		end
		// rready is registered, so this transfer is certain
		if (rvalid && rready) begin
			beat_sent = 1'b1;
			if (beat_idx == burst_len) begin
				burst_open = 1'b0;
			end
			beat_idx = beat_idx + 8'd1;
		end
		arready = !cur.stall || rng[2];
		if (reset_n && arvalid && arready) begin
			check_ar();
		end
		win_ready = !cur.stall || rng[4:3] != 2'd0;
		if (reset_n && win_valid && win_ready) begin
			check_window();
		end
	end

	// ------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------
	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (busy !== level) begin
			report_failure($sformatf("busy did not go %s within %0d cycles",
				level ? "high" : "low", limit));
		end
	endtask

	task automatic run_case(input case_t c);
		cur = c;
		win_cnt = 0;
		exp_layer = 0;
		exp_row = 0;
		exp_col = 0;
		ar_cnt = 0;
		ar_layer = 0;
		ar_row = 0;
		cfg.base_slot = c.base;
		cfg.rows = c.rows;
		cfg.cols = c.cols;
		cfg.layers = c.layers;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_busy(1'b1, 4);
		wait_busy(1'b0, RUN_LIMIT);
		assert (win_cnt == int'(c.count))
			else report_failure($sformatf("[FAIL] window count got %h expected %h", win_cnt, c.count));
		assert (ar_cnt == int'(c.rows) * int'(c.layers))
			else report_failure($sformatf("[FAIL] AR count got %h expected %h",
				ar_cnt, int'(c.rows) * int'(c.layers)));
	endtask

	initial begin
		forever #20 clk = ~clk;
	end

	initial begin
		reset_n = 1'b0;
		start = 1'b0;
		cfg = '0;
		arready = 1'b0;
		r = '0;
		rvalid = 1'b0;
		win_ready = 1'b0;
		rng = 32'h3f85_61bc;
		cur = '0;
		burst_open = 1'b0;
		beat_sent = 1'b0;
		burst_addr = '0;
		burst_len = '0;
		beat_idx = '0;
		// rows, cols, layers, base slot, stall, windows
		cases[0] = '{10'd5, 10'd8, 10'd1, 12'd0, 1'b0, 16'd40};
		cases[1] = '{10'd3, 10'd6, 10'd1, 12'd2, 1'b0, 16'd18};
		cases[2] = '{10'd4, 10'd16, 10'd3, 12'd5, 1'b0, 16'd192};
		cases[3] = '{10'd4, 10'd16, 10'd3, 12'd5, 1'b1, 16'd192};
		cases[4] = '{10'd7, 10'd21, 10'd2, 12'd9, 1'b1, 16'd294};
		cases[5] = '{10'd3, 10'd64, 10'd1, 12'd1, 1'b1, 16'd192};
		repeat (10) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		assert (!busy && !win_valid && !arvalid && !rready)
			else report_failure("control outputs were not idle after reset");
		for (int i = 0; i < NUM_CASES; i++) begin
			run_case(cases[i]);
			repeat (3) @(negedge clk);
		end
		if (u_input_layer_top.u_chk.fail_cnt == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			report_failure("a bound handshake assertion failed");
		end
	end

endmodule

// ==== verification/input_layer_chk.sv ====
// bound assertions: AR and window handshake stability, rready through a burst, idle in reset, no X
`timescale 1ns/100ps

module input_layer_chk (
	input logic                       clk,
	input logic                       reset_n,
	input axi_rd_pkg::ar_req_t        ar,
	input logic                       arvalid,
	input logic                       arready,
	input axi_rd_pkg::r_beat_t        r,
	input logic                       rvalid,
	input logic                       rready,
	input layer_geom_pkg::win_t       win,
	input logic                       win_valid,
	input logic                       win_ready,
	input logic                       busy
);

	// failures seen so far, polled by the testbench
	int fail_cnt = 0;

	// ------------------------------------------------------------
	// valid holds with stable payload until the transfer
	// ------------------------------------------------------------
	ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		arvalid && !arready |=> arvalid && $stable(ar))
		else begin
			fail_cnt++;
			$error("AR request dropped or changed before it was accepted");
		end

	// buffer never stalls, rready stays up until the last beat
	r_open: assert property (@(posedge clk) disable iff (!reset_n)
		(arvalid && arready) || (rvalid && rready && !r.last) |=> rready)
		else begin
			fail_cnt++;
			$error("rready dropped while a read burst was open");
		end

	win_hold: assert property (@(posedge clk) disable iff (!reset_n)
		win_valid && !win_ready |=> win_valid && $stable(win))
		else begin
			fail_cnt++;
			$error("window dropped or changed while the stream was stalled");
		end

	// ------------------------------------------------------------
	// reset and known values
	// ------------------------------------------------------------
	// one edge of reset clears all handshake outputs
	reset_idle: assert property (@(posedge clk)
		!reset_n |=> !arvalid && !rready && !win_valid && !busy)
		else begin
			fail_cnt++;
			$error("a control output stayed active through reset");
		end

	ctrl_known: assert property (@(posedge clk) disable iff (!reset_n)
		!$isunknown({arvalid, rready, win_valid, busy}))
		else begin
			fail_cnt++;
			$error("a control output is unknown after reset");
		end

endmodule

// ==== hdl/input_layer_top.sv ====
// input_layer_top: fetch, line buffer and window stages with fixed AXI read attributes
`timescale 1ns/100ps

module input_layer_top #(
	parameter int MAX_COLS_P = layer_geom_pkg::MAX_COLS,
	parameter int MAX_ROWS_P = layer_geom_pkg::MAX_ROWS
) (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic                            start,
	input  layer_geom_pkg::layer_cfg_t      cfg,
	output axi_rd_pkg::ar_req_t             ar,
	output logic                            arvalid,
	input  logic                            arready,
	output logic [axi_rd_pkg::ID_W-1:0]     arid,
	output logic [2:0]                      arsize,
	output logic [1:0]                      arburst,
	input  axi_rd_pkg::r_beat_t             r,
	input  logic                            rvalid,
	output logic                            rready,
	output layer_geom_pkg::win_t            win,
	output logic                            win_valid,
	input  logic                            win_ready,
	output logic                            busy
);
	import layer_geom_pkg::*;
	import axi_rd_pkg::*;

	// fetch to buffer
	r_beat_t beat;
	logic beat_valid;
	logic slot_free;
	// buffer to streamer
	logic [2:0] rows_ready;
	logic [23:0] col_bytes;
	logic [DIM_W-1:0] col_addr;
	logic row_release;
	logic layer_flush;
	logic last_row;

	// fixed read attributes
	assign arid = AR_ID;
	assign arsize = AR_SIZE;
	assign arburst = BURST_INCR;

	// ------------------------------------------------------------
	// stages
	// ------------------------------------------------------------
	row_fetcher u_fetch (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.cfg(cfg),
		.slot_free(slot_free),
		.arready(arready),
		.r(r),
		.rvalid(rvalid),
		.ar(ar),
		.arvalid(arvalid),
		.rready(rready),
		.beat(beat),
		.beat_valid(beat_valid),
		.fetch_done()
	);

	line_buffer #(
		.MAX_COLS_P(MAX_COLS_P)
	) u_lbuf (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.beat(beat),
		.beat_valid(beat_valid),
		.col_addr(col_addr),
		.row_release(row_release),
		.layer_flush(layer_flush),
		.last_row(last_row),
		.slot_free(slot_free),
		.rows_ready(rows_ready),
		.col_bytes(col_bytes)
	);

	window_streamer #(
		.MAX_ROWS_P(MAX_ROWS_P)
	) u_win (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.cfg(cfg),
		.rows_ready(rows_ready),
		.col_bytes(col_bytes),
		.win_ready(win_ready),
		.col_addr(col_addr),
		.row_release(row_release),
		.layer_flush(layer_flush),
		.last_row(last_row),
		.win(win),
		.win_valid(win_valid),
		.busy(busy)
	);

endmodule

// ==== hdl/window_streamer.sv ====
// window_streamer: column walk over buffered rows, 3x3 shift window, tagged valid/ready output
`timescale 1ns/100ps

module window_streamer #(
	parameter int MAX_ROWS_P = layer_geom_pkg::MAX_ROWS
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              start,
	input  layer_geom_pkg::layer_cfg_t        cfg,
	input  logic [2:0]                        rows_ready,
	input  logic [23:0]                       col_bytes,
	input  logic                              win_ready,
	output logic [layer_geom_pkg::DIM_W-1:0]  col_addr,
	output logic                              row_release,
	output logic                              layer_flush,
	output logic                              last_row,
	output layer_geom_pkg::win_t              win,
	output logic                              win_valid,
	output logic                              busy
);
	import layer_geom_pkg::*;

	// PRE0/PRE1 preload two columns, OUT emits one window per transfer
	typedef enum logic [1:0] {
		S_IDLE,
		S_PRE0,
		S_PRE1,
		S_OUT
	} state_t;

	state_t state;
	logic [DIM_W-1:0] rows_q;
	logic [DIM_W-1:0] cols_q;
	logic [DIM_W-1:0] layers_q;
	logic [DIM_W-1:0] layer_q;
	logic [DIM_W-1:0] row_q;
	logic [DIM_W-1:0] col_q;
	logic [DIM_W-1:0] nxt_col;
	// window columns, each {up, mid, down}
	logic [23:0] win_l;
	logic [23:0] win_c;
	logic [23:0] win_r;
	logic [2:0] need;
	logic accept;
	logic row_done;
	logic last_layer;

	// ------------------------------------------------------------
	// handshake and row bookkeeping
	// ------------------------------------------------------------
	assign win_valid = (state == S_OUT);
	assign accept = win_valid && win_ready;
	assign row_done = accept && (col_q == cols_q - 1'b1);
	assign last_row = (row_q == rows_q - 1'b1);
	assign last_layer = (layer_q == layers_q - 1'b1);
	assign row_release = row_done;
	assign layer_flush = row_done && last_row;

	// slots for rows r-1, r, r+1, padding rows excluded
	assign need = 3'd1 + 3'(row_q != '0) + 3'(!last_row);

	// column to fetch next, past the row goes out of range
	always_comb begin
		case (state)
			S_PRE0: nxt_col = '0;
			S_PRE1: nxt_col = DIM_W'(1);
			default: nxt_col = col_q + DIM_W'(2);
		endcase
		col_addr = (nxt_col < cols_q) ? nxt_col : '1;
	end

	// ------------------------------------------------------------
	// window FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
			busy <= 1'b0;
			rows_q <= '0;
			cols_q <= '0;
			layers_q <= '0;
			layer_q <= '0;
			row_q <= '0;
			col_q <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						// clamp to the tallest layer
						rows_q <= (cfg.rows > DIM_W'(MAX_ROWS_P)) ? DIM_W'(MAX_ROWS_P) : cfg.rows;
						cols_q <= cfg.cols;
						layers_q <= cfg.layers;
						layer_q <= '0;
						row_q <= '0;
						col_q <= '0;
						busy <= 1'b1;
						state <= S_PRE0;
					end
				end
				S_PRE0: begin
					// neighbours loaded, take column 0
					if (rows_ready >= need) begin
						win_l <= '0;
						win_c <= '0;
						win_r <= col_bytes;
						state <= S_PRE1;
					end
				end
				S_PRE1: begin
					// zero left column at column 0
					win_l <= win_c;
					win_c <= win_r;
					win_r <= col_bytes;
					col_q <= '0;
					state <= S_OUT;
				end
				S_OUT: begin
					if (row_done) begin
						state <= S_PRE0;
						if (last_row) begin
							row_q <= '0;
							if (last_layer) begin
								busy <= 1'b0;
								state <= S_IDLE;
							end else begin
								layer_q <= layer_q + 1'b1;
							end
						end else begin
							row_q <= row_q + 1'b1;
						end
					end else if (accept) begin
						win_l <= win_c;
						win_c <= win_r;
						win_r <= col_bytes;
						col_q <= col_q + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// output word
	// ------------------------------------------------------------
	// row-major, top-left first
	always_comb begin
		win.data = {win_l[23:16], win_c[23:16], win_r[23:16],
			win_l[15:8], win_c[15:8], win_r[15:8],
			win_l[7:0], win_c[7:0], win_r[7:0]};
		win.layer = layer_q;
		win.row = row_q;
		win.col = col_q;
	end

endmodule

// ==== hdl/line_buffer.sv ====
// line_buffer: four row slots filled from read beats, three-row column read with padding
`timescale 1ns/100ps

module line_buffer #(
	parameter int MAX_COLS_P = layer_geom_pkg::MAX_COLS
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              start,
	input  axi_rd_pkg::r_beat_t               beat,
	input  logic                              beat_valid,
	input  logic [layer_geom_pkg::DIM_W-1:0]  col_addr,
	input  logic                              row_release,
	input  logic                              layer_flush,
	input  logic                              last_row,
	output logic                              slot_free,
	output logic [2:0]                        rows_ready,
	output logic [23:0]                       col_bytes
);
	import axi_rd_pkg::*;

	localparam int BEATS_P = MAX_COLS_P / BEAT_BYTES;
	localparam int BC_W = $clog2(BEATS_P + 1);
	localparam int CA_W = $clog2(MAX_COLS_P);

	// slot storage, byte addressed by column
	logic [7:0] mem [4][MAX_COLS_P];
	logic [1:0] wr_ptr;
	logic [1:0] old_ptr;
	logic [BC_W-1:0] beat_cnt;
	// oldest slot holds row 0 of the layer, nothing above it
	logic top_row;
	logic row_in;
	logic [2:0] drop;
	logic [1:0] up_slot;
	logic [1:0] mid_slot;
	logic [1:0] dn_slot;
	logic [CA_W-1:0] ca;

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	// beat byte k lands at column beat_cnt*8 + k
	always_ff @(posedge clk) begin
		if (beat_valid && beat_cnt < BC_W'(BEATS_P)) begin
			for (int k = 0; k < BEAT_BYTES; k++) begin
				mem[wr_ptr][int'(beat_cnt) * BEAT_BYTES + k] <= beat.data[8*k +: 8];
			end
		end
	end

	assign row_in = beat_valid && beat.last;

	// slots given back this cycle
	always_comb begin
		if (layer_flush) begin
			// rest of the finished layer; next layer rows stay
			drop = top_row ? 3'd1 : 3'd2;
		end else if (row_release && !top_row) begin
			drop = 3'd1;
		end else begin
			drop = 3'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			wr_ptr <= '0;
			old_ptr <= '0;
			beat_cnt <= '0;
			rows_ready <= '0;
			top_row <= 1'b1;
		end else begin
			if (beat_valid) begin
				if (beat.last) begin
					beat_cnt <= '0;
					wr_ptr <= wr_ptr + 1'b1;
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end
			rows_ready <= rows_ready + 3'(row_in) - drop;
			old_ptr <= old_ptr + drop[1:0];
			if (layer_flush) begin
				top_row <= 1'b1;
			end else if (row_release) begin
				top_row <= 1'b0;
			end
		end
	end

	// one open slot is enough for a whole burst
	assign slot_free = (rows_ready < 3'd4);

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	// columns past the row arrive out of range and read as zero
	always_comb begin
		up_slot = old_ptr;
		mid_slot = top_row ? old_ptr : old_ptr + 2'd1;
		dn_slot = mid_slot + 2'd1;
		ca = col_addr[CA_W-1:0];
		col_bytes = '0;
		if (col_addr < MAX_COLS_P) begin
			if (!top_row) begin
				col_bytes[23:16] = mem[up_slot][ca];
			end
			col_bytes[15:8] = mem[mid_slot][ca];
			// zero row below the last one
			if (!last_row) begin
				col_bytes[7:0] = mem[dn_slot][ca];
			end
		end
	end

endmodule

// ==== hdl/row_fetcher.sv ====
// row_fetcher: layer-major row walk, one AXI4 read burst per row into the line buffer
`timescale 1ns/100ps

module row_fetcher (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     start,
	input  layer_geom_pkg::layer_cfg_t cfg,
	input  logic                     slot_free,
	input  logic                     arready,
	input  axi_rd_pkg::r_beat_t      r,
	input  logic                     rvalid,
	output axi_rd_pkg::ar_req_t      ar,
	output logic                     arvalid,
	output logic                     rready,
	output axi_rd_pkg::r_beat_t      beat,
	output logic                     beat_valid,
	output logic                     fetch_done
);
	import layer_geom_pkg::*;
	import axi_rd_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_AR,
		S_DATA
	} state_t;

	state_t state;
	// latched geometry
	logic [BASE_W-1:0] base_q;
	logic [DIM_W-1:0] rows_q;
	logic [DIM_W-1:0] layers_q;
	logic [7:0] len_q;
	// walk position
	logic [DIM_W-1:0] row_q;
	logic [DIM_W-1:0] layer_q;
	logic [ADDR_W-1:0] row_addr;
	logic burst_end;
	logic last_row;
	logic last_burst;

	// ------------------------------------------------------------
	// address and burst bookkeeping
	// ------------------------------------------------------------
	// slot of the layer, then row pitch inside it
	assign row_addr = (ADDR_W'(base_q) + ADDR_W'(layer_q)) * LAYER_SLOT_BYTES
		+ ADDR_W'(row_q) * ROW_PITCH_BYTES;

	// line buffer never stalls, so take beats whenever a burst is open
	assign rready = (state == S_DATA);
	assign beat = r;
	assign beat_valid = rvalid && rready;
	assign burst_end = beat_valid && r.last;

	assign last_row = (row_q == rows_q - 1'b1);
	assign last_burst = last_row && (layer_q == layers_q - 1'b1);

	// ------------------------------------------------------------
	// fetch FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
			arvalid <= 1'b0;
			fetch_done <= 1'b0;
			base_q <= '0;
			rows_q <= '0;
			layers_q <= '0;
			len_q <= '0;
			row_q <= '0;
			layer_q <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						base_q <= cfg.base_slot;
						rows_q <= cfg.rows;
						layers_q <= cfg.layers;
						// ceil(cols/8) - 1 beats
						len_q <= 8'((cfg.cols - 1'b1) / BEAT_BYTES);
						row_q <= '0;
						layer_q <= '0;
						fetch_done <= 1'b0;
						state <= S_REQ;
					end
				end
				S_REQ: begin
					// wait for an empty slot so the burst never backs up
					if (slot_free) begin
						ar.addr <= row_addr;
						ar.len <= len_q;
						arvalid <= 1'b1;
						state <= S_AR;
					end
				end
				S_AR: begin
					if (arready) begin
						arvalid <= 1'b0;
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (burst_end) begin
						if (last_burst) begin
							fetch_done <= 1'b1;
							state <= S_IDLE;
						end else begin
							// layer after layer
							if (last_row) begin
								row_q <= '0;
								layer_q <= layer_q + 1'b1;
							end else begin
								row_q <= row_q + 1'b1;
							end
							state <= S_REQ;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/axi_rd_pkg.sv ====
// AXI4 read channel widths, fixed AR attributes, address request and read beat structs
package axi_rd_pkg;

	// ------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int ID_W = 3;
	// bytes per read beat
	localparam int BEAT_BYTES = 8;

	// ------------------------------------------------------------
	// fixed AR attributes
	// ------------------------------------------------------------
	// 8 bytes per beat
	localparam logic [2:0] AR_SIZE = 3'd3;
	localparam logic [1:0] BURST_INCR = 2'b01;
	// single outstanding id
	localparam logic [ID_W-1:0] AR_ID = 3'd1;

	// address channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;	// beats minus one
	} ar_req_t;

	// read data channel payload, 67 bits
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              last;
		logic [1:0]        resp;
	} r_beat_t;

endpackage

// ==== hdl/layer_geom_pkg.sv ====
// feature-map geometry limits, layer slot layout, config and window structs
package layer_geom_pkg;

	// ------------------------------------------------------------
	// geometry limits
	// ------------------------------------------------------------
	// widest row in bytes
	localparam int MAX_COLS = 64;
	// tallest layer in rows
	localparam int MAX_ROWS = 64;
	// row, column and layer counters
	localparam int DIM_W = 10;
	// base address is given in whole layer slots
	localparam int BASE_W = 12;

	// ------------------------------------------------------------
	// memory layout
	// ------------------------------------------------------------
	// one layer per 4 KiB slot, so a row burst never crosses 4K
	localparam int LAYER_SLOT_BYTES = 4096;
	// fixed row pitch inside the slot
	localparam int ROW_PITCH_BYTES = 64;
	// 3x3 window
	localparam int WIN_BYTES = 9;

	// latched on start
	typedef struct packed {
		logic [BASE_W-1:0] base_slot;	// byte address is base_slot * 4 KiB
		logic [DIM_W-1:0]  rows;
		logic [DIM_W-1:0]  cols;
		logic [DIM_W-1:0]  layers;
	} layer_cfg_t;

	// data is row-major, top-left byte in the msbs
	typedef struct packed {
		logic [WIN_BYTES*8-1:0] data;
		logic [DIM_W-1:0]       layer;
		logic [DIM_W-1:0]       row;
		logic [DIM_W-1:0]       col;	// column of the centre byte
	} win_t;

endpackage
